//--- common/fu_params.svh
`ifndef FU_PARAMS_SVH
`define FU_PARAMS_SVH

// datapath widths
`define XLEN        32
`define PRN_W       6   // physical register tag
`define ROBN_W      5   // rob index

// result queue entries, also the issuer's starting credits per unit
`define QUEUE_DEPTH 4

`define MULT_STAGES 4   // partial product stages in the multiplier
`define CDB_CREDITS 2   // writeback slots the consumer starts with

`endif

//--- common/fu_pkg.sv
`include "fu_params.svh"

package fu_pkg;

    typedef logic [`XLEN-1:0]   data_t;
    typedef logic [`XLEN-1:0]   addr_t;
    typedef logic [`PRN_W-1:0]  prn_t;
    typedef logic [`ROBN_W-1:0] robn_t;
    typedef logic [31:0]        inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_func_t;

    // order follows funct3 of the M extension
    typedef enum logic [1:0] {
        MULT_MUL,
        MULT_MULH,
        MULT_MULHSU,
        MULT_MULHU
    } mult_func_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_select_t;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_select_t;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_unit_t;

    typedef struct packed {
        robn_t robn;
        prn_t  prn;
        data_t result;       // branch target for branches
        logic  is_branch;
        logic  take_branch;
    } alu_result_t;

    typedef struct packed {
        robn_t robn;
        prn_t  prn;
        data_t result;
    } mult_result_t;

endpackage

//--- verilog/fu_issue.sv
`include "fu_params.svh"

module fu_issue import fu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  fu_unit_t    issue_unit,
    input  alu_func_t   issue_alu_func,
    input  mult_func_t  issue_mult_func,
    input  opa_select_t issue_opa_select,
    input  opb_select_t issue_opb_select,
    input  inst_t       issue_inst,
    input  addr_t       issue_pc,
    input  data_t       issue_op1,
    input  data_t       issue_op2,
    input  prn_t        issue_dest_prn,
    input  robn_t       issue_robn,
    input  logic        issue_cond_branch,
    input  logic        issue_uncond_branch,
    output logic        alu_valid,
    output logic        mult_valid,
    output data_t       opa,
    output data_t       opb,
    output data_t       br_op1,
    output data_t       br_op2,
    output logic [2:0]  br_funct3,
    output alu_func_t   alu_func,
    output mult_func_t  mult_func,
    output addr_t       pc,
    output logic        cond_branch,
    output logic        uncond_branch,
    output prn_t        dest_prn,
    output robn_t       robn
);

    data_t opa_mux, opb_mux;
    data_t i_imm, s_imm, b_imm, u_imm, j_imm;

    // immediates straight from the instruction word
    assign i_imm = {{20{issue_inst[31]}}, issue_inst[31:20]};
    assign s_imm = {{20{issue_inst[31]}}, issue_inst[31:25], issue_inst[11:7]};
    assign b_imm = {{19{issue_inst[31]}}, issue_inst[31], issue_inst[7],
                    issue_inst[30:25], issue_inst[11:8], 1'b0};
    assign u_imm = {issue_inst[31:12], 12'b0};
    assign j_imm = {{11{issue_inst[31]}}, issue_inst[31], issue_inst[19:12],
                    issue_inst[20], issue_inst[30:21], 1'b0};

    always_comb begin
        case (issue_opa_select)
            OPA_IS_RS1:  opa_mux = issue_op1;
            OPA_IS_PC:   opa_mux = issue_pc;    // branch/jump target base, auipc
            OPA_IS_ZERO: opa_mux = '0;          // lui
            default:     opa_mux = 32'hdeadface; // marker, unused encoding
        endcase
    end

    always_comb begin
        case (issue_opb_select)
            OPB_IS_RS2:   opb_mux = issue_op2;
            OPB_IS_I_IMM: opb_mux = i_imm;
            OPB_IS_S_IMM: opb_mux = s_imm;
            OPB_IS_B_IMM: opb_mux = b_imm;
            OPB_IS_U_IMM: opb_mux = u_imm;
            OPB_IS_J_IMM: opb_mux = j_imm;
            default:      opb_mux = 32'hfacefeed;
        endcase
    end

    // exactly one unit sees each accepted op
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_valid  <= 1'b0;
            mult_valid <= 1'b0;
        end else begin
            alu_valid  <= issue_valid && (issue_unit == FU_ALU);
            mult_valid <= issue_valid && (issue_unit == FU_MULT);
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin // hold payload between ops
            opa           <= opa_mux;
            opb           <= opb_mux;
            br_op1        <= issue_op1;  // raw regs for the compare
            br_op2        <= issue_op2;
            br_funct3     <= issue_inst[14:12];
            alu_func      <= issue_alu_func;
            mult_func     <= issue_mult_func;
            pc            <= issue_pc;
            cond_branch   <= issue_cond_branch;
            uncond_branch <= issue_uncond_branch;
            dest_prn      <= issue_dest_prn;
            robn          <= issue_robn;
        end
    end

endmodule

//--- verilog/alu_cond.sv
`include "fu_params.svh"

module alu_cond import fu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       alu_valid,
    input  data_t      opa,
    input  data_t      opb,
    input  data_t      br_op1,
    input  data_t      br_op2,
    input  logic [2:0] br_funct3,
    input  alu_func_t  alu_func,
    input  logic       cond_branch,
    input  logic       uncond_branch,
    input  prn_t       dest_prn,
    input  robn_t      robn,
    output logic       res_valid,
    output robn_t      res_robn,
    output prn_t       res_prn,
    output data_t      res_value,
    output logic       res_is_branch,
    output logic       res_take_branch
);

    data_t alu_out;
    logic  cond_take;

    always_comb begin
        case (alu_func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_SLT:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {31'b0, opa < opb};
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLL:  alu_out = opa << opb[4:0];
            ALU_SRL:  alu_out = opa >> opb[4:0];
            ALU_SRA:  alu_out = $signed(opa) >>> opb[4:0]; // sign fill
            default:  alu_out = 32'hfacebeec; // marker for a bad func
        endcase
    end

    // condition on funct3, compares the raw register values
    always_comb begin
        case (br_funct3)
            3'b000:  cond_take = br_op1 == br_op2;                   // beq
            3'b001:  cond_take = br_op1 != br_op2;                   // bne
            3'b100:  cond_take = $signed(br_op1) < $signed(br_op2);  // blt
            3'b101:  cond_take = $signed(br_op1) >= $signed(br_op2); // bge
            3'b110:  cond_take = br_op1 < br_op2;                    // bltu
            3'b111:  cond_take = br_op1 >= br_op2;                   // bgeu
            default: cond_take = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= alu_valid;
        end
    end

    // for branches the alu sum is the target (pc + imm)
    always_ff @(posedge clock) begin
        if (alu_valid) begin
            res_robn        <= robn;
            res_prn         <= dest_prn;
            res_value       <= alu_out;
            res_is_branch   <= cond_branch || uncond_branch;
            res_take_branch <= uncond_branch || (cond_branch && cond_take); // jumps always
        end
    end

endmodule

//--- mult/mult_pipe.sv
`include "fu_params.svh"

module mult_pipe import fu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       mult_valid,
    input  data_t      opa,
    input  data_t      opb,
    input  mult_func_t mult_func,
    input  prn_t       dest_prn,
    input  robn_t      robn,
    output logic       res_valid,
    output robn_t      res_robn,
    output prn_t       res_prn,
    output data_t      res_value
);

    localparam int SLICE = 64 / `MULT_STAGES; // multiplier bits per stage
    localparam int LAST  = `MULT_STAGES - 1;

    logic        signed_a, signed_b;
    logic [32:0] ext_a, ext_b;

    // stage 0 inputs come from the ports
    logic [63:0] in_acc   [`MULT_STAGES];
    logic [63:0] in_mcand [`MULT_STAGES];
    logic [63:0] in_mplr  [`MULT_STAGES];
    mult_func_t  in_func  [`MULT_STAGES];
    robn_t       in_robn  [`MULT_STAGES];
    prn_t        in_prn   [`MULT_STAGES];

    logic [`MULT_STAGES-1:0] st_valid;
    logic [63:0] st_acc   [`MULT_STAGES];
    logic [63:0] st_mcand [`MULT_STAGES];
    logic [63:0] st_mplr  [`MULT_STAGES];
    mult_func_t  st_func  [`MULT_STAGES];
    robn_t       st_robn  [`MULT_STAGES];
    prn_t        st_prn   [`MULT_STAGES];

    always_comb begin
        case (mult_func)
            MULT_MULH:   {signed_a, signed_b} = 2'b11;
            MULT_MULHSU: {signed_a, signed_b} = 2'b10;
            default:     {signed_a, signed_b} = 2'b00; // mul low word is sign-blind
        endcase
    end

    assign ext_a = {signed_a & opa[31], opa};
    assign ext_b = {signed_b & opb[31], opb};

    always_comb begin
        in_acc[0]   = '0;
        in_mcand[0] = {{31{ext_a[32]}}, ext_a}; // widened to 64 bits for a mod 2^64 product
        in_mplr[0]  = {{31{ext_b[32]}}, ext_b};
        in_func[0]  = mult_func;
        in_robn[0]  = robn;
        in_prn[0]   = dest_prn;
        for (int s = 1; s < `MULT_STAGES; s++) begin
            in_acc[s]   = st_acc[s-1];
            in_mcand[s] = st_mcand[s-1];
            in_mplr[s]  = st_mplr[s-1];
            in_func[s]  = st_func[s-1];
            in_robn[s]  = st_robn[s-1];
            in_prn[s]   = st_prn[s-1];
        end
    end

    // each stage adds one partial product and shifts the operands on
    always_ff @(posedge clock) begin
        for (int s = 0; s < `MULT_STAGES; s++) begin
            st_acc[s]   <= in_acc[s] + in_mcand[s] * in_mplr[s][SLICE-1:0];
            st_mcand[s] <= in_mcand[s] << SLICE;
            st_mplr[s]  <= in_mplr[s] >> SLICE;
            st_func[s]  <= in_func[s];
            st_robn[s]  <= in_robn[s];
            st_prn[s]   <= in_prn[s];
        end
        res_robn  <= st_robn[LAST];
        res_prn   <= st_prn[LAST];
        res_value <= (st_func[LAST] == MULT_MUL) ? st_acc[LAST][31:0] : st_acc[LAST][63:32];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            st_valid  <= '0;
            res_valid <= 1'b0;
        end else begin
            st_valid  <= {st_valid[`MULT_STAGES-2:0], mult_valid};
            res_valid <= st_valid[LAST];
        end
    end

endmodule

//--- verilog/result_queue.sv
`include "fu_params.svh"

module result_queue import fu_pkg::*; #(
    parameter type payload_t = alu_result_t,
    parameter int  DEPTH     = `QUEUE_DEPTH
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     not_empty,
    output payload_t head,
    output logic     credit
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic          full;

    assign full      = (count == CW'(DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr]; // visible the cycle after the write

    always_ff @(posedge clock) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count  <= count + CW'(push) - CW'(pop);
            credit <= pop; // one slot back to the issuer per pop
        end
    end

    // issuer credits must cover every slot
    assert property (@(posedge clock) disable iff (reset) !(push && full));
    assert property (@(posedge clock) disable iff (reset) !(pop && !not_empty));

endmodule

//--- verilog/cdb_arbiter.sv
`include "fu_params.svh"

module cdb_arbiter import fu_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         alu_ready,
    input  alu_result_t  alu_head,
    input  logic         mult_ready,
    input  mult_result_t mult_head,
    input  logic         cdb_credit,
    output logic         alu_pop,
    output logic         mult_pop,
    output logic         cdb_valid,
    output robn_t        cdb_robn,
    output prn_t         cdb_prn,
    output data_t        cdb_value,
    output logic         cdb_is_branch,
    output logic         cdb_take_branch
);

    localparam int CW = $clog2(`CDB_CREDITS + 1);

    logic [CW-1:0] credits;   // free writeback slots at the consumer
    logic          last_mult; // mult won the last beat
    logic          can_send;

    assign can_send = (credits != '0);

    // round robin, alu goes first unless it won last time and mult waits
    assign alu_pop  = can_send && alu_ready && (!mult_ready || last_mult);
    assign mult_pop = can_send && mult_ready && !alu_pop;

    always_ff @(posedge clock) begin
        if (reset) begin
            credits   <= CW'(`CDB_CREDITS);
            last_mult <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            credits   <= credits + CW'(cdb_credit) - CW'(alu_pop || mult_pop);
            cdb_valid <= alu_pop || mult_pop;
            if (alu_pop || mult_pop) last_mult <= mult_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_pop) begin
            cdb_robn        <= alu_head.robn;
            cdb_prn         <= alu_head.prn;
            cdb_value       <= alu_head.result;
            cdb_is_branch   <= alu_head.is_branch;
            cdb_take_branch <= alu_head.take_branch;
        end else if (mult_pop) begin
            cdb_robn        <= mult_head.robn;
            cdb_prn         <= mult_head.prn;
            cdb_value       <= mult_head.result;
            cdb_is_branch   <= 1'b0; // never a branch
            cdb_take_branch <= 1'b0;
        end
    end

    // consumer never hands back more than it was given
    assert property (@(posedge clock) disable iff (reset) credits <= CW'(`CDB_CREDITS));

endmodule

//--- verilog/fu_top.sv
`include "fu_params.svh"

module fu_top import fu_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  fu_unit_t    issue_unit,
    input  alu_func_t   issue_alu_func,
    input  mult_func_t  issue_mult_func,
    input  opa_select_t issue_opa_select,
    input  opb_select_t issue_opb_select,
    input  inst_t       issue_inst,
    input  addr_t       issue_pc,
    input  data_t       issue_op1,
    input  data_t       issue_op2,
    input  prn_t        issue_dest_prn,
    input  robn_t       issue_robn,
    input  logic        issue_cond_branch,
    input  logic        issue_uncond_branch,
    output logic        alu_credit,
    output logic        mult_credit,
    output logic        cdb_valid,
    output robn_t       cdb_robn,
    output prn_t        cdb_prn,
    output data_t       cdb_value,
    output logic        cdb_is_branch,
    output logic        cdb_take_branch,
    input  logic        cdb_credit
);

    logic       alu_valid, mult_valid;
    data_t      opa, opb, br_op1, br_op2;
    logic [2:0] br_funct3;
    alu_func_t  alu_func;
    mult_func_t mult_func;
    logic       cond_branch, uncond_branch;
    prn_t       dest_prn;
    robn_t      robn;

    logic  alu_res_valid, alu_res_is_branch, alu_res_take;
    robn_t alu_res_robn;
    prn_t  alu_res_prn;
    data_t alu_res_value;

    logic  mult_res_valid;
    robn_t mult_res_robn;
    prn_t  mult_res_prn;
    data_t mult_res_value;

    alu_result_t  alu_push_data, alu_head;
    mult_result_t mult_push_data, mult_head;
    logic         alu_not_empty, mult_not_empty, alu_pop, mult_pop;

    fu_issue u_issue (
        .clock, .reset, .issue_valid, .issue_unit, .issue_alu_func, .issue_mult_func,
        .issue_opa_select, .issue_opb_select, .issue_inst, .issue_pc, .issue_op1,
        .issue_op2, .issue_dest_prn, .issue_robn, .issue_cond_branch, .issue_uncond_branch,
        .alu_valid, .mult_valid, .opa, .opb, .br_op1, .br_op2, .br_funct3, .alu_func,
        .mult_func,
        .pc            (), // target already formed through opa, no link value here
        .cond_branch, .uncond_branch, .dest_prn, .robn
    );

    alu_cond u_alu (
        .clock, .reset, .alu_valid, .opa, .opb, .br_op1, .br_op2, .br_funct3, .alu_func,
        .cond_branch, .uncond_branch, .dest_prn, .robn,
        .res_valid       (alu_res_valid),
        .res_robn        (alu_res_robn),
        .res_prn         (alu_res_prn),
        .res_value       (alu_res_value),
        .res_is_branch   (alu_res_is_branch),
        .res_take_branch (alu_res_take)
    );

    mult_pipe u_mult (
        .clock, .reset, .mult_valid, .opa, .opb, .mult_func, .dest_prn, .robn,
        .res_valid (mult_res_valid),
        .res_robn  (mult_res_robn),
        .res_prn   (mult_res_prn),
        .res_value (mult_res_value)
    );

    assign alu_push_data  = '{robn: alu_res_robn, prn: alu_res_prn, result: alu_res_value,
                              is_branch: alu_res_is_branch, take_branch: alu_res_take};
    assign mult_push_data = '{robn: mult_res_robn, prn: mult_res_prn,
                              result: mult_res_value};

    // one queue per unit, credits go straight back to the issuer
    result_queue #(.payload_t(alu_result_t), .DEPTH(`QUEUE_DEPTH)) u_alu_q (
        .clock, .reset,
        .push      (alu_res_valid),
        .push_data (alu_push_data),
        .pop       (alu_pop),
        .not_empty (alu_not_empty),
        .head      (alu_head),
        .credit    (alu_credit)
    );

    result_queue #(.payload_t(mult_result_t), .DEPTH(`QUEUE_DEPTH)) u_mult_q (
        .clock, .reset,
        .push      (mult_res_valid),
        .push_data (mult_push_data),
        .pop       (mult_pop),
        .not_empty (mult_not_empty),
        .head      (mult_head),
        .credit    (mult_credit)
    );

    cdb_arbiter u_arb (
        .clock, .reset,
        .alu_ready  (alu_not_empty),
        .alu_head,
        .mult_ready (mult_not_empty),
        .mult_head, .cdb_credit, .alu_pop, .mult_pop, .cdb_valid, .cdb_robn, .cdb_prn,
        .cdb_value, .cdb_is_branch, .cdb_take_branch
    );

endmodule

//--- sim/fu_tb.sv
`include "fu_params.svh"

module fu_tb import fu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS = 28;
    localparam int FIELDS  = 14;  // hex words per pattern line
    localparam int TIMEOUT = 400; // cycles allowed per wait

    typedef struct packed {
        robn_t robn;
        prn_t  prn;
        data_t value;
        logic  is_branch;
        logic  take;
    } expect_t;

    logic        clock;
    logic        reset;
    logic        issue_valid;
    fu_unit_t    issue_unit;
    alu_func_t   issue_alu_func;
    mult_func_t  issue_mult_func;
    opa_select_t issue_opa_select;
    opb_select_t issue_opb_select;
    inst_t       issue_inst;
    addr_t       issue_pc;
    data_t       issue_op1;
    data_t       issue_op2;
    prn_t        issue_dest_prn;
    robn_t       issue_robn;
    logic        issue_cond_branch;
    logic        issue_uncond_branch;
    logic        alu_credit;
    logic        mult_credit;
    logic        cdb_valid;
    robn_t       cdb_robn;
    prn_t        cdb_prn;
    data_t       cdb_value;
    logic        cdb_is_branch;
    logic        cdb_take_branch;
    logic        cdb_credit;

    logic [31:0] pat_mem [NUM_OPS*FIELDS];
    expect_t     alu_exp[$];  // per unit in issue order
    expect_t     mult_exp[$];
    int          alu_credits;
    int          mult_credits;
    int          cdb_held;    // beats taken but credit not yet handed back
    int          hold_off;    // cycles until the next credit return
    int          beats;
    logic [31:0] rng_state;

    fu_top UUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t expected);
        if (got !== expected)
            fail_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, expected));
    endtask

    task automatic check_robn(input string name, input robn_t got, input robn_t expected);
        if (got !== expected)
            fail_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, expected));
    endtask

    task automatic check_prn(input string name, input prn_t got, input prn_t expected);
        if (got !== expected)
            fail_run($sformatf("ERR t=%0t %s got %h expected %h", $time, name, got, expected));
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
            fail_run($sformatf("ERR t=%0t %s got %b expected %b", $time, name, got, expected));
    endtask

    task automatic wait_for_credit(input fu_unit_t unit);
        int waited;
        waited = 0;
        while ((unit == FU_ALU) ? (alu_credits == 0) : (mult_credits == 0)) begin
            if (waited == TIMEOUT)
                fail_run("timeout waiting for CDB result to free an issue credit");
            @(posedge clock);
            #2;
            waited++;
        end
    endtask

    // drives pattern line i 2 ns after a rising edge
    task automatic issue_op(input int i);
        int      base;
        expect_t e;
        base = i * FIELDS;
        wait_for_credit(fu_unit_t'(pat_mem[base][0]));
        issue_unit          = fu_unit_t'(pat_mem[base][0]);
        issue_alu_func      = alu_func_t'(pat_mem[base+1][3:0]);
        issue_mult_func     = mult_func_t'(pat_mem[base+1][1:0]);
        issue_opa_select    = opa_select_t'(pat_mem[base+2][1:0]);
        issue_opb_select    = opb_select_t'(pat_mem[base+3][2:0]);
        issue_inst          = pat_mem[base+4];
        issue_pc            = pat_mem[base+5];
        issue_op1           = pat_mem[base+6];
        issue_op2           = pat_mem[base+7];
        issue_dest_prn      = prn_t'(pat_mem[base+8]);
        issue_robn          = robn_t'(pat_mem[base+9]);
        issue_cond_branch   = pat_mem[base+10][0];
        issue_uncond_branch = pat_mem[base+11][0];
        issue_valid         = 1'b1;
        e.robn      = issue_robn;
        e.prn       = issue_dest_prn;
        e.value     = pat_mem[base+12];
        e.is_branch = issue_cond_branch | issue_uncond_branch; // mult lines carry zeros
        e.take      = pat_mem[base+13][0];
        if (issue_unit == FU_ALU) begin
            alu_credits--;
            alu_exp.push_back(e);
        end else begin
            mult_credits--;
            mult_exp.push_back(e);
        end
    endtask

    // a CDB beat must sit at the head of the queue holding its robn
    task automatic take_beat();
        expect_t e;
        logic    in_alu;
        logic    in_mult;
        in_alu  = 1'b0;
        in_mult = 1'b0;
        if (cdb_held >= `CDB_CREDITS)
            fail_run("CDB beat sent with no writeback credit left");
        foreach (alu_exp[k]) if (alu_exp[k].robn == cdb_robn) in_alu = 1'b1;
        foreach (mult_exp[k]) if (mult_exp[k].robn == cdb_robn) in_mult = 1'b1;
        if (in_alu) begin
            e = alu_exp.pop_front();
        end else if (in_mult) begin
            e = mult_exp.pop_front();
        end else begin
            fail_run($sformatf("robn %0d on the CDB was never issued or came twice", cdb_robn));
        end
        check_robn("cdb_robn", cdb_robn, e.robn); // catches reordering within a unit
        check_prn("cdb_prn", cdb_prn, e.prn);
        check_data("cdb_value", cdb_value, e.value);
        check_flag("cdb_is_branch", cdb_is_branch, e.is_branch);
        check_flag("cdb_take_branch", cdb_take_branch, e.take);
        cdb_held++;
        beats++;
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // consumer hands credits back after random delays
    initial begin
        cdb_credit = 1'b0;
        cdb_held   = 0;
        hold_off   = 40; // withhold at first so the queues fill up
        rng_state  = 32'h476f6a3a;
        forever begin
            @(posedge clock);
            #2;
            cdb_credit = 1'b0;
            if (!reset) begin
                if (hold_off > 0) begin
                    hold_off--;
                end else if (cdb_held > 0) begin
                    cdb_credit = 1'b1;
                    cdb_held--;
                    rng_state  = xorshift32(rng_state);
                    hold_off   = int'(rng_state[3:0]);
                end
            end
        end
    end

    // outputs sampled mid cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (alu_credit) alu_credits++;
            if (mult_credit) mult_credits++;
            if (alu_credits > `QUEUE_DEPTH || mult_credits > `QUEUE_DEPTH)
                fail_run("more issue credits came back than ops were issued");
            if (cdb_valid) take_beat();
        end
    end

    initial begin
        int waited;
        reset               = 1'b1;
        issue_valid         = 1'b0;
        issue_unit          = FU_ALU;
        issue_alu_func      = ALU_ADD;
        issue_mult_func     = MULT_MUL;
        issue_opa_select    = OPA_IS_RS1;
        issue_opb_select    = OPB_IS_RS2;
        issue_inst          = '0;
        issue_pc            = '0;
        issue_op1           = '0;
        issue_op2           = '0;
        issue_dest_prn      = '0;
        issue_robn          = '0;
        issue_cond_branch   = 1'b0;
        issue_uncond_branch = 1'b0;
        alu_credits         = `QUEUE_DEPTH;
        mult_credits        = `QUEUE_DEPTH;
        beats               = 0;
        $readmemh("sim/fu_patterns.txt", pat_mem);

        repeat (7) @(posedge clock);
        @(negedge clock);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        check_flag("alu_credit", alu_credit, 1'b0);
        check_flag("mult_credit", mult_credit, 1'b0);
        @(posedge clock); // eighth edge in reset
        #2;
        reset = 1'b0;
        @(posedge clock); // first edge out of reset
        @(negedge clock);
        check_flag("cdb_valid", cdb_valid, 1'b0);
        check_flag("alu_credit", alu_credit, 1'b0);
        check_flag("mult_credit", mult_credit, 1'b0);
        @(posedge clock);
        #2;

        for (int i = 0; i < NUM_OPS; i++) begin
            issue_op(i);
            @(posedge clock);
            #2;
            issue_valid = 1'b0; // raised again at once if a credit is there
        end

        // drain until all results are out and all credits home
        waited = 0;
        while (alu_exp.size() != 0 || mult_exp.size() != 0 ||
               alu_credits != `QUEUE_DEPTH || mult_credits != `QUEUE_DEPTH) begin
            if (waited == TIMEOUT) fail_run("timeout waiting for CDB result");
            @(posedge clock);
            waited++;
        end

        if (beats == NUM_OPS) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d CDB beats seen for %0d issued ops", beats, NUM_OPS));
        end
    end

endmodule

//--- sim/fu_patterns.txt
// unit func opa_sel opb_sel inst pc op1 op2 prn robn cond uncond expected take, all hex
// unit 0 is the ALU and 1 the multiplier, func holds that unit's enum code
0 0 0 0 00000033 00000000 00000005 00000007 20 00 0 0 0000000c 0
1 0 0 0 02000033 00000000 00001234 00005678 21 01 0 0 06260060 0
0 1 0 0 40000033 00000000 00000005 00000007 22 02 0 0 fffffffe 0
0 2 0 0 00002033 00000000 ffffffff 00000001 23 03 0 0 00000001 0
1 1 0 0 02001033 00000000 ffffffff 00000003 24 04 0 0 ffffffff 0
0 3 0 0 00003033 00000000 ffffffff 00000001 25 05 0 0 00000000 0
0 4 0 0 00007033 00000000 f0f0f0f0 0ff00ff0 26 06 0 0 00f000f0 0
0 5 0 0 00006033 00000000 f0f0f0f0 0ff00ff0 27 07 0 0 fff0fff0 0
1 2 0 0 02002033 00000000 00000002 ffffffff 28 08 0 0 00000001 0
0 6 0 0 00004033 00000000 f0f0f0f0 0ff00ff0 29 09 0 0 ff00ff00 0
0 7 0 0 00001033 00000000 00000003 00000004 2a 0a 0 0 00000030 0
0 8 0 0 00005033 00000000 80000000 00000004 2b 0b 0 0 08000000 0
0 9 0 0 40005033 00000000 80000000 00000004 2c 0c 0 0 f8000000 0
1 3 0 0 02003033 00000000 ffffffff 00000003 2d 0d 0 0 00000002 0
1 3 0 0 02003033 00000000 ffffffff ffffffff 2e 0e 0 0 fffffffe 0
0 0 0 1 ff000013 00000000 00000100 00000000 2f 0f 0 0 000000f0 0
0 9 0 1 40305013 00000000 fffffff0 00000000 30 10 0 0 fffffffe 0
0 0 2 4 12345037 00000000 00000000 00000000 31 11 0 0 12345000 0
0 0 1 4 00001017 00400000 00000000 00000000 32 12 0 0 00401000 0
0 0 0 2 fe002e23 00000000 00001000 00000000 33 13 0 0 00000ffc 0
0 0 1 3 00000863 00001000 00000007 00000007 34 14 1 0 00001010 1
0 0 1 3 fe001ce3 00008000 00000001 00000002 35 15 1 0 00007ff8 1
0 0 1 3 00004863 00003000 fffffffe 00000001 36 16 1 0 00003010 1
0 0 1 3 00005863 00004000 fffffffe 00000001 37 17 1 0 00004010 0
0 0 1 3 00006863 00005000 fffffffe 00000001 38 18 1 0 00005010 0
0 0 1 3 00007863 00006000 fffffffe 00000001 39 19 1 0 00006010 1
0 0 1 5 0010006f 00009000 00000000 00000000 3a 1a 0 1 00009800 1
0 0 0 1 00400067 00000000 0000a000 00000000 3b 1b 0 1 0000a004 1

//--- sources.f
+incdir+common
common/fu_pkg.sv
verilog/fu_issue.sv
verilog/alu_cond.sv
mult/mult_pipe.sv
verilog/result_queue.sv
verilog/cdb_arbiter.sv
verilog/fu_top.sv
sim/fu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the execution stage testbench with Verilator and runs it from the project root
# the exit status is the simulation's own
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module fu_tb -o fu_sim &&
./obj_dir/fu_sim ||
{ echo "execution stage simulation failed"; exit 1; }
